// File: raster_vectors.txt
# T v0x v0y v1x v1y v2x v2y c0 c1 c2 d0 d1 d2 (hex, coordinates in 1/16 pixel)
# F x y rgb565 depth (hex, expected fragments of the T line above, in scan order)
T 0 0 20 0 0 20 F00 0F0 00F 10000 10000 10000
F 0 0 8208 10000
T 0 0 0 20 20 0 F00 00F 0F0 C000 C000 C000
F 0 0 8208 C000
T 20 0 20 20 0 20 F00 0F0 00F 20000 20000 20000
F 1 0 B808 20000
F 0 1 4017 20000
F 1 1 4408 20000
T 0 0 20 0 0 20 F00 0F0 00F C000 C000 C000
T 20 0 20 20 0 20 F00 0F0 00F 30000 30000 30000
T 0 0 10 10 20 20 FFF FFF FFF 10000 10000 10000
T 80 0 C0 0 80 40 F00 0F0 00F 0 40000 80000
F 8 0 B904 18000
F 9 0 8304 28000
F A 0 44E4 38000
F 8 1 810C 38000
F 9 1 430C 48000
F 8 2 4113 58000

// File: project.f
+incdir+.
raster_pkg.sv
triangle_setup.sv
pixel_scan.sv
pixel_eval.sv
depth_test.sv
raster_core.sv
raster_checker.sv
tb_raster.sv

// File: Bender.yml
package:
  name: raster_core

sources:
  - include_dirs:
      - .
    files:
      - raster_pkg.sv
      - triangle_setup.sv
      - pixel_scan.sv
      - pixel_eval.sv
      - depth_test.sv
      - raster_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - raster_checker.sv
      - tb_raster.sv

// File: tb_raster.sv
`timescale 1ns/1ps
`include "raster_defines.svh"

module tb_raster
    import raster_pkg::*;
();
    localparam int MAX_TRI  = 32;
    localparam int MAX_FRAG = 256;

    logic       clk;
    logic       rst;
    sub_coord_t v0x, v0y, v1x, v1y, v2x, v2y;
    color12_t   v0_color, v1_color, v2_color;
    q16_16_t    v0_depth, v1_depth, v2_depth;
    logic       tri_load;
    logic       tri_ready;
    logic       tri_done;
    coord_x_t   frag_x;
    coord_y_t   frag_y;
    color16_t   frag_color;
    q16_16_t    frag_depth;
    logic       frag_valid;
    logic       frag_ready;

    string       tri_lines  [MAX_TRI];
    int          tri_frags  [MAX_TRI];
    string       frag_lines [MAX_FRAG];
    int          frag_tri   [MAX_FRAG];
    int          num_tri;
    int          num_frag;
    int          cycle_count;
    int          cycle_limit;
    logic        loaded;
    int unsigned lcg_state = 92061;

    raster_core UUT (
        .clk, .rst, .v0x, .v0y, .v1x, .v1y, .v2x, .v2y,
        .v0_color, .v1_color, .v2_color, .v0_depth, .v1_depth, .v2_depth,
        .tri_load, .tri_ready, .tri_done,
        .frag_x, .frag_y, .frag_color, .frag_depth, .frag_valid, .frag_ready
    );

    raster_checker u_check (
        .clk, .rst, .frag_x, .frag_y, .frag_color, .frag_depth,
        .frag_valid, .frag_ready, .tri_done, .tri_ready
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Sink stalls about one cycle in four
    always @(negedge clk) begin
        lcg_state  = lcg_next(lcg_state);
        frag_ready = (lcg_state[17:16] != 2'b00);
    end

    task automatic read_vectors(output logic ok);
        int    fd;
        string line;
        num_tri  = 0;
        num_frag = 0;
        ok       = 1'b1;
        fd = $fopen("raster_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open raster_vectors.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] == "T" && num_tri < MAX_TRI) begin
                    tri_lines[num_tri] = line;
                    tri_frags[num_tri] = 0;
                    num_tri++;
                end else if (line.len() > 0 && line[0] == "F" && num_tri > 0
                             && num_frag < MAX_FRAG) begin
                    frag_lines[num_frag] = line;
                    frag_tri[num_frag]   = num_tri - 1;
                    tri_frags[num_tri-1]++;
                    num_frag++;
                end
            end
            $fclose(fd);
            if (num_tri == 0) begin
                $display("No triangles found in raster_vectors.txt");
                ok = 1'b0;
            end
        end
    endtask

    task automatic run_triangle(input int t);
        int          i;
        logic [7:0]  fx, fy;
        logic [15:0] fc;
        logic [31:0] fd;
        logic [11:0] c0, c1, c2;
        @(negedge clk);
        while (!tri_ready) @(negedge clk);
        u_check.start_triangle(t, tri_frags[t]);
        for (i = 0; i < num_frag; i++) begin
            if (frag_tri[i] == t) begin
                void'($sscanf(frag_lines[i], "F %h %h %h %h", fx, fy, fc, fd));
                u_check.push_expected(coord_x_t'(fx), coord_y_t'(fy),
                                      color16_t'(fc), q16_16_t'(fd));
            end
        end
        void'($sscanf(tri_lines[t], "T %h %h %h %h %h %h %h %h %h %h %h %h",
                      v0x, v0y, v1x, v1y, v2x, v2y, c0, c1, c2,
                      v0_depth, v1_depth, v2_depth));
        v0_color = c0;
        v1_color = c1;
        v2_color = c2;
        tri_load = 1'b1;
        @(negedge clk);
        tri_load = 1'b0;
        @(posedge clk);
        while (!tri_done) @(posedge clk);
        // tri_ready is due back one cycle after tri_done
        @(posedge clk);
    endtask

    initial begin
        logic ok;
        int   t;
        rst        = 1'b1;
        loaded     = 1'b0;
        tri_load   = 1'b0;
        frag_ready = 1'b0;
        v0x        = '0;
        v0y        = '0;
        v1x        = '0;
        v1y        = '0;
        v2x        = '0;
        v2y        = '0;
        v0_color   = '0;
        v1_color   = '0;
        v2_color   = '0;
        v0_depth   = '0;
        v1_depth   = '0;
        v2_depth   = '0;
        read_vectors(ok);
        cycle_limit = num_tri * (`RASTER_WIDTH * `RASTER_HEIGHT
                      + `RASTER_DENOM_INV_BITS + 40) * 4;
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (ok) begin
            for (t = 0; t < num_tri; t++) begin
                run_triangle(t);
            end
        end
        repeat (2) @(negedge clk);
        $display("Triangles passed: %0d, failed: %0d", u_check.pass_count, u_check.fail_count);
        if (ok && u_check.fail_count == 0 && u_check.pass_count == num_tri) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the triangle count
    initial begin
        cycle_count = 0;
        wait (loaded === 1'b1);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the run hung waiting for tri_done", cycle_count);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: raster_checker.sv
`timescale 1ns/1ps

module raster_checker
    import raster_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire coord_x_t frag_x,
    input  wire coord_y_t frag_y,
    input  wire color16_t frag_color,
    input  wire q16_16_t  frag_depth,
    input  wire logic     frag_valid,
    input  wire logic     frag_ready,
    input  wire logic     tri_done,
    input  wire logic     tri_ready
);
    coord_x_t exp_x     [$];
    coord_y_t exp_y     [$];
    color16_t exp_color [$];
    q16_16_t  exp_depth [$];

    int       tri_id;
    int       tri_expected;
    int       tri_got;
    logic     tri_err;
    int       pass_count;
    int       fail_count;
    logic     done_d;

    // Copy of a fragment stalled by the sink
    logic     held;
    coord_x_t held_x;
    coord_y_t held_y;
    color16_t held_color;
    q16_16_t  held_depth;

    initial begin
        tri_id       = 0;
        tri_expected = 0;
        tri_got      = 0;
        tri_err      = 1'b0;
        pass_count   = 0;
        fail_count   = 0;
        done_d       = 1'b0;
        held         = 1'b0;
    end

    task automatic start_triangle(input int id, input int count);
        tri_id       = id;
        tri_expected = count;
        tri_got      = 0;
        tri_err      = 1'b0;
    endtask

    task automatic push_expected(input coord_x_t x, input coord_y_t y,
                                 input color16_t c, input q16_16_t d);
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_color.push_back(c);
        exp_depth.push_back(d);
    endtask

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
            tri_err = 1'b1;
        end
    endtask

    task automatic finish_triangle();
        if (exp_x.size() != 0 || tri_got != tri_expected) begin
            $display("Triangle %0d: expected %0d fragments but received %0d",
                     tri_id, tri_expected, tri_got);
            tri_err = 1'b1;
        end
        exp_x.delete();
        exp_y.delete();
        exp_color.delete();
        exp_depth.delete();
        if (tri_err) begin
            $display("FAIL triangle %0d", tri_id);
            fail_count++;
        end else begin
            $display("PASS triangle %0d, %0d fragments", tri_id, tri_got);
            pass_count++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (held && frag_valid) begin
                check_field("frag_x while held", held_x, frag_x);
                check_field("frag_y while held", held_y, frag_y);
                check_field("frag_color while held", held_color, frag_color);
                check_field("frag_depth while held", held_depth, frag_depth);
            end else if (held) begin
                $display("Triangle %0d: a stalled fragment vanished before it was taken",
                         tri_id);
                tri_err = 1'b1;
            end
            held = frag_valid && !frag_ready;
            if (held) begin
                held_x     = frag_x;
                held_y     = frag_y;
                held_color = frag_color;
                held_depth = frag_depth;
            end
            if (frag_valid && frag_ready) begin
                tri_got++;
                if (exp_x.size() == 0) begin
                    $display("Triangle %0d: unexpected fragment at x %0d y %0d",
                             tri_id, frag_x, frag_y);
                    tri_err = 1'b1;
                end else begin
                    check_field("frag_x", exp_x.pop_front(), frag_x);
                    check_field("frag_y", exp_y.pop_front(), frag_y);
                    check_field("frag_color", exp_color.pop_front(), frag_color);
                    check_field("frag_depth", exp_depth.pop_front(), frag_depth);
                end
            end
            // Core is free again one cycle after the triangle ends
            if (done_d) begin
                check_field("tri_ready", 32'd1, tri_ready);
                finish_triangle();
            end
            // Still busy with the load while the triangle drains
            if (tri_done) begin
                check_field("tri_ready", 32'd0, tri_ready);
            end
            done_d = tri_done;
        end
    end

endmodule

// File: raster_core.sv
`timescale 1ns/1ps

module raster_core
    import raster_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire sub_coord_t v0x, v0y, v1x, v1y, v2x, v2y,
    input  wire color12_t   v0_color, v1_color, v2_color,
    input  wire q16_16_t    v0_depth, v1_depth, v2_depth,
    input  wire logic       tri_load,
    output      logic       tri_ready,
    output      logic       tri_done,
    output      coord_x_t   frag_x,
    output      coord_y_t   frag_y,
    output      color16_t   frag_color,
    output      q16_16_t    frag_depth,
    output      logic       frag_valid,
    input  wire logic       frag_ready
);
    sub_coord_t s_v0x, s_v0y, e0x, e0y, e1x, e1y;
    denom_inv_t denom_inv;
    color12_t   c0, c1, c2;
    q16_16_t    d0, d1, d2;
    coord_x_t   bbox_x0, bbox_x1, pixel_x, out_x;
    coord_y_t   bbox_y0, bbox_y1, pixel_y, out_y;
    logic       load_go, setup_done, setup_empty;
    logic       in_valid, in_ready, eval_busy, result_busy;
    color16_t   out_color;
    q16_16_t    out_depth;
    logic       out_valid, out_ready;

    // A load is only taken while the core is free
    assign load_go = tri_load && tri_ready;

    triangle_setup u_setup (
        .clk, .rst, .tri_load(load_go),
        .v0x, .v0y, .v1x, .v1y, .v2x, .v2y,
        .v0_color, .v1_color, .v2_color, .v0_depth, .v1_depth, .v2_depth,
        .v0x_q(s_v0x), .v0y_q(s_v0y), .e0x, .e0y, .e1x, .e1y, .denom_inv,
        .c0, .c1, .c2, .d0, .d1, .d2,
        .bbox_x0, .bbox_x1, .bbox_y0, .bbox_y1, .setup_done, .setup_empty
    );

    pixel_scan u_scan (
        .clk, .rst, .tri_load, .setup_done, .setup_empty,
        .bbox_x0, .bbox_x1, .bbox_y0, .bbox_y1,
        .in_ready, .eval_busy, .result_busy,
        .pixel_x, .pixel_y, .in_valid, .tri_done, .tri_ready
    );

    pixel_eval u_eval (
        .clk, .rst, .pixel_x, .pixel_y, .v0x(s_v0x), .v0y(s_v0y),
        .e0x, .e0y, .e1x, .e1y, .denom_inv,
        .v0_color(c0), .v1_color(c1), .v2_color(c2),
        .v0_depth(d0), .v1_depth(d1), .v2_depth(d2),
        .in_valid, .in_ready, .out_x, .out_y, .out_color, .out_depth,
        .out_valid, .out_ready, .busy(eval_busy)
    );

    depth_test u_depth (
        .clk, .rst, .out_x, .out_y, .out_color, .out_depth, .out_valid, .out_ready,
        .frag_x, .frag_y, .frag_color, .frag_depth, .frag_valid, .frag_ready,
        .busy(result_busy)
    );

endmodule

// File: depth_test.sv
`timescale 1ns/1ps
`include "raster_defines.svh"

module depth_test
    import raster_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire coord_x_t out_x,
    input  wire coord_y_t out_y,
    input  wire color16_t out_color,
    input  wire q16_16_t  out_depth,
    input  wire logic     out_valid,
    output      logic     out_ready,
    output      coord_x_t frag_x,
    output      coord_y_t frag_y,
    output      color16_t frag_color,
    output      q16_16_t  frag_depth,
    output      logic     frag_valid,
    input  wire logic     frag_ready,
    output      logic     busy
);
    localparam int NPIX = `RASTER_WIDTH * `RASTER_HEIGHT;

    q16_16_t                   zbuf [NPIX];
    logic [NPIX-1:0]           zvalid;
    logic [$clog2(NPIX)-1:0]   idx;
    logic                      pass;
    logic                      write;

    assign idx       = {out_y, out_x};
    assign out_ready = !frag_valid || frag_ready;
    // Strictly nearer wins, equal depth loses
    assign pass      = !zvalid[idx] || (out_depth < zbuf[idx]);
    assign write     = out_valid && out_ready && pass;
    assign busy      = frag_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            zvalid     <= '0;
            frag_valid <= 1'b0;
        end else begin
            if (out_ready) frag_valid <= out_valid && pass;
            if (write) zvalid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            zbuf[idx]  <= out_depth;
            frag_x     <= out_x;
            frag_y     <= out_y;
            frag_color <= out_color;
            frag_depth <= out_depth;
        end
    end

endmodule

// File: pixel_eval.sv
`timescale 1ns/1ps
`include "raster_defines.svh"

module pixel_eval
    import raster_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire coord_x_t   pixel_x,
    input  wire coord_y_t   pixel_y,
    input  wire sub_coord_t v0x, v0y,
    input  wire sub_coord_t e0x, e0y, e1x, e1y,
    input  wire denom_inv_t denom_inv,
    input  wire color12_t   v0_color, v1_color, v2_color,
    input  wire q16_16_t    v0_depth, v1_depth, v2_depth,
    input  wire logic       in_valid,
    output      logic       in_ready,
    output      coord_x_t   out_x,
    output      coord_y_t   out_y,
    output      color16_t   out_color,
    output      q16_16_t    out_depth,
    output      logic       out_valid,
    input  wire logic       out_ready,
    output      logic       busy
);
    localparam int SB     = `RASTER_SUBPIXEL_BITS;
    localparam int WS     = `RASTER_DENOM_INV_FBITS - 16;
    localparam int PROD_W = $bits(area_t) + `RASTER_DENOM_INV_BITS;

    localparam logic signed [PROD_W-1:0] HALF_W = 1 <<< (WS - 1);
    localparam q16_16_t                  ONE    = 32'sh0001_0000;

    logic [1:6] vld;
    logic [1:7] rdy;
    coord_x_t   px [1:6];
    coord_y_t   py [1:6];

    sub_coord_t s2_e2x, s2_e2y;
    area_t      s3_vnum, s3_wnum, s3_unum;
    area_t      s4_vnum, s4_wnum;
    logic       s4_inside, s4_inside_d;
    q16_16_t    s5_uw, s5_vw, s5_ww;
    q16_16_t    s5_uw_d, s5_vw_d, s5_ww_d;
    color16_t   s6_color, s6_color_d;
    q16_16_t    s6_depth, s6_depth_d;

    // Edge direction test, reversed for clockwise winding
    function automatic logic top_left(input sub_coord_t dx, input sub_coord_t dy,
                                      input logic flip);
        sub_coord_t fx;
        sub_coord_t fy;
        fx = flip ? -dx : dx;
        fy = flip ? -dy : dy;
        return (fy < 0) || ((fy == 0) && (fx > 0));
    endfunction

    function automatic logic edge_ok(input area_t n, input logic inc);
        return (n > 0) || ((n == 0) && inc);
    endfunction

    function automatic q16_16_t clamp_w(input logic signed [PROD_W-1:0] r);
        if (r < 0) return '0;
        if (r > ONE) return ONE;
        return q16_16_t'(r);
    endfunction

    function automatic logic [5:0] mix(input q16_16_t wa, input q16_16_t wb, input q16_16_t wc,
                                       input logic [5:0] ca, input logic [5:0] cb,
                                       input logic [5:0] cc, input logic [5:0] top);
        logic [31:0] acc;
        acc = ($unsigned(wa) * ca + $unsigned(wb) * cb + $unsigned(wc) * cc + 32'h8000) >> 16;
        return (acc > 32'(top)) ? top : acc[5:0];
    endfunction

    always_comb begin
        rdy[7] = !out_valid || out_ready;
        for (int i = 6; i >= 1; i--) begin
            rdy[i] = !vld[i] || rdy[i+1];
        end
    end

    assign in_ready = rdy[1];
    assign busy     = (|vld) || out_valid;

    // Inside test on numerators normalised to a positive area
    always_comb begin
        logic  neg;
        area_t vn, wn, un;
        neg = denom_inv < 0;
        vn  = neg ? -s3_vnum : s3_vnum;
        wn  = neg ? -s3_wnum : s3_wnum;
        un  = neg ? -s3_unum : s3_unum;
        s4_inside_d = edge_ok(vn, top_left(-e1x, -e1y, neg))
                   && edge_ok(wn, top_left(e0x, e0y, neg))
                   && edge_ok(un, top_left(e1x - e0x, e1y - e0y, neg));
    end

    always_comb begin
        logic signed [PROD_W-1:0] vm, wm;
        vm      = s4_vnum * denom_inv;
        wm      = s4_wnum * denom_inv;
        s5_vw_d = clamp_w((vm + HALF_W) >>> WS);
        s5_ww_d = clamp_w((wm + HALF_W) >>> WS);
        s5_uw_d = ONE - s5_vw_d - s5_ww_d;
        if (s5_uw_d < 0) s5_uw_d = '0;
    end

    // 4-bit channels widen by repeating their top bits
    always_comb begin
        logic signed [63:0] dsum;
        logic [5:0]         r6;
        logic [5:0]         b6;
        r6 = mix(s5_uw, s5_vw, s5_ww,
                 {1'b0, v0_color.r, v0_color.r[3]},
                 {1'b0, v1_color.r, v1_color.r[3]},
                 {1'b0, v2_color.r, v2_color.r[3]}, 6'd31);
        b6 = mix(s5_uw, s5_vw, s5_ww,
                 {1'b0, v0_color.b, v0_color.b[3]},
                 {1'b0, v1_color.b, v1_color.b[3]},
                 {1'b0, v2_color.b, v2_color.b[3]}, 6'd31);
        s6_color_d.r = r6[4:0];
        s6_color_d.g = mix(s5_uw, s5_vw, s5_ww,
                           {v0_color.g, v0_color.g[3:2]},
                           {v1_color.g, v1_color.g[3:2]},
                           {v2_color.g, v2_color.g[3:2]}, 6'd63);
        s6_color_d.b = b6[4:0];
        dsum = s5_uw * v0_depth + s5_vw * v1_depth + s5_ww * v2_depth + 64'sh8000;
        s6_depth_d = q16_16_t'(dsum >>> 16);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (rdy[1]) vld[1] <= in_valid;
            for (int i = 2; i <= 6; i++) begin
                // Pixels outside the triangle leave after stage 4
                if (rdy[i]) vld[i] <= (i == 5) ? (vld[i-1] && s4_inside) : vld[i-1];
            end
            if (rdy[7]) out_valid <= vld[6];
        end
    end

    always_ff @(posedge clk) begin
        if (rdy[1]) begin
            px[1] <= pixel_x;
            py[1] <= pixel_y;
        end
        for (int i = 2; i <= 6; i++) begin
            if (rdy[i]) begin
                px[i] <= px[i-1];
                py[i] <= py[i-1];
            end
        end
        // Offset of the pixel centre from v0
        if (rdy[2]) begin
            s2_e2x <= sub_coord_t'({px[1], 1'b1, {(SB-1){1'b0}}}) - v0x;
            s2_e2y <= sub_coord_t'({py[1], 1'b1, {(SB-1){1'b0}}}) - v0y;
        end
        if (rdy[3]) begin
            s3_vnum <= s2_e2x * e1y - s2_e2y * e1x;
            s3_wnum <= e0x * s2_e2y - e0y * s2_e2x;
            s3_unum <= (e0x * e1y - e0y * e1x) - (s2_e2x * e1y - s2_e2y * e1x)
                     - (e0x * s2_e2y - e0y * s2_e2x);
        end
        if (rdy[4]) begin
            s4_vnum   <= s3_vnum;
            s4_wnum   <= s3_wnum;
            s4_inside <= s4_inside_d;
        end
        if (rdy[5]) begin
            s5_uw <= s5_uw_d;
            s5_vw <= s5_vw_d;
            s5_ww <= s5_ww_d;
        end
        if (rdy[6]) begin
            s6_color <= s6_color_d;
            s6_depth <= s6_depth_d;
        end
        if (rdy[7]) begin
            out_x     <= px[6];
            out_y     <= py[6];
            out_color <= s6_color;
            out_depth <= s6_depth;
        end
    end

endmodule

// File: pixel_scan.sv
`timescale 1ns/1ps

module pixel_scan
    import raster_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     tri_load,
    input  wire logic     setup_done,
    input  wire logic     setup_empty,
    input  wire coord_x_t bbox_x0,
    input  wire coord_x_t bbox_x1,
    input  wire coord_y_t bbox_y0,
    input  wire coord_y_t bbox_y1,
    input  wire logic     in_ready,
    input  wire logic     eval_busy,
    input  wire logic     result_busy,
    output      coord_x_t pixel_x,
    output      coord_y_t pixel_y,
    output      logic     in_valid,
    output      logic     tri_done,
    output      logic     tri_ready
);
    typedef enum logic [1:0] {IDLE, SCAN, DRAIN} state_t;

    state_t state;
    logic   take;

    assign take = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            pixel_x   <= '0;
            pixel_y   <= '0;
            in_valid  <= 1'b0;
            tri_done  <= 1'b0;
            tri_ready <= 1'b1;
        end else begin
            tri_done <= 1'b0;
            if (tri_load && tri_ready) begin
                tri_ready <= 1'b0;
            end else if (tri_done) begin
                tri_ready <= 1'b1;
            end

            case (state)
                IDLE: begin
                    if (setup_done) begin
                        pixel_x  <= bbox_x0;
                        pixel_y  <= bbox_y0;
                        in_valid <= 1'b1;
                        state    <= SCAN;
                    end else if (setup_empty) begin
                        state <= DRAIN;
                    end
                end
                SCAN: begin
                    if (take) begin
                        if (pixel_x != bbox_x1) begin
                            pixel_x <= pixel_x + 1'b1;
                        end else if (pixel_y != bbox_y1) begin
                            pixel_x <= bbox_x0;
                            pixel_y <= pixel_y + 1'b1;
                        end else begin
                            in_valid <= 1'b0;
                            state    <= DRAIN;
                        end
                    end
                end
                default: begin
                    // Triangle ends once nothing is left in flight
                    if (!eval_busy && !result_busy) begin
                        tri_done <= 1'b1;
                        state    <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: triangle_setup.sv
`timescale 1ns/1ps
`include "raster_defines.svh"

module triangle_setup
    import raster_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       tri_load,
    input  wire sub_coord_t v0x, v0y, v1x, v1y, v2x, v2y,
    input  wire color12_t   v0_color, v1_color, v2_color,
    input  wire q16_16_t    v0_depth, v1_depth, v2_depth,
    output      sub_coord_t v0x_q, v0y_q,
    output      sub_coord_t e0x, e0y, e1x, e1y,
    output      denom_inv_t denom_inv,
    output      color12_t   c0, c1, c2,
    output      q16_16_t    d0, d1, d2,
    output      coord_x_t   bbox_x0, bbox_x1,
    output      coord_y_t   bbox_y0, bbox_y1,
    output      logic       setup_done,
    output      logic       setup_empty
);
    localparam int SB = `RASTER_SUBPIXEL_BITS;
    localparam int QW = `RASTER_DENOM_INV_BITS;
    localparam int AW = $bits(area_t);

    typedef enum logic [2:0] {S_IDLE, S_AREA, S_INIT, S_DIV, S_SIGN} state_t;

    state_t                state;
    logic [$clog2(QW)-1:0] cnt;
    area_t                 area;
    logic [AW-1:0]         mag;
    logic [AW-1:0]         rem;
    logic [QW-1:0]         quo;
    logic [QW-1:0]         qsat;
    logic [AW:0]           trial;

    // Next partial remainder with the following dividend bit shifted in
    assign trial = {rem, quo[QW-1]};
    // Only a unit area overflows the signed result
    assign qsat  = quo[QW-1] ? {1'b0, {(QW-1){1'b1}}} : quo;

    function automatic sub_coord_t min3(input sub_coord_t a, input sub_coord_t b,
                                        input sub_coord_t c);
        sub_coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic sub_coord_t max3(input sub_coord_t a, input sub_coord_t b,
                                        input sub_coord_t c);
        sub_coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // Pixel index holding a subpixel coordinate, clamped to the screen
    function automatic int pix(input sub_coord_t v, input int last);
        int p;
        p = int'(v >>> SB);
        if (p < 0) p = 0;
        if (p > last) p = last;
        return p;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= S_IDLE;
            cnt         <= '0;
            setup_done  <= 1'b0;
            setup_empty <= 1'b0;
        end else begin
            setup_done  <= 1'b0;
            setup_empty <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (tri_load) state <= S_AREA;
                end
                S_AREA: state <= S_INIT;
                S_INIT: begin
                    cnt <= '0;
                    if (area == '0) begin
                        setup_empty <= 1'b1;
                        state       <= S_IDLE;
                    end else begin
                        state <= S_DIV;
                    end
                end
                S_DIV: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == QW - 1) state <= S_SIGN;
                end
                default: begin
                    setup_done <= 1'b1;
                    state      <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (tri_load) begin
                    v0x_q <= v0x;
                    v0y_q <= v0y;
                    e0x   <= v1x - v0x;
                    e0y   <= v1y - v0y;
                    e1x   <= v2x - v0x;
                    e1y   <= v2y - v0y;
                    c0    <= v0_color;
                    c1    <= v1_color;
                    c2    <= v2_color;
                    d0    <= v0_depth;
                    d1    <= v1_depth;
                    d2    <= v2_depth;
                end
            end
            S_AREA: begin
                area    <= e0x * e1y - e0y * e1x;
                bbox_x0 <= coord_x_t'(pix(min3(v0x_q, v0x_q + e0x, v0x_q + e1x),
                                          `RASTER_WIDTH - 1));
                bbox_x1 <= coord_x_t'(pix(max3(v0x_q, v0x_q + e0x, v0x_q + e1x),
                                          `RASTER_WIDTH - 1));
                bbox_y0 <= coord_y_t'(pix(min3(v0y_q, v0y_q + e0y, v0y_q + e1y),
                                          `RASTER_HEIGHT - 1));
                bbox_y1 <= coord_y_t'(pix(max3(v0y_q, v0y_q + e0y, v0y_q + e1y),
                                          `RASTER_HEIGHT - 1));
            end
            S_INIT: begin
                mag <= (area < 0) ? -area : area;
                rem <= '0;
                quo <= QW'(1) << `RASTER_DENOM_INV_FBITS;
            end
            S_DIV: begin
                // Restoring step, one quotient bit per cycle
                if (trial >= {1'b0, mag}) begin
                    rem <= AW'(trial - {1'b0, mag});
                    quo <= {quo[QW-2:0], 1'b1};
                end else begin
                    rem <= trial[AW-1:0];
                    quo <= {quo[QW-2:0], 1'b0};
                end
            end
            default: begin
                denom_inv <= (area < 0) ? -denom_inv_t'(qsat) : denom_inv_t'(qsat);
            end
        endcase
    end

endmodule

// File: raster_pkg.sv
`include "raster_defines.svh"

package raster_pkg;

    localparam int SUB_W = 16 + `RASTER_SUBPIXEL_BITS;

    typedef logic [$clog2(`RASTER_WIDTH)-1:0]  coord_x_t;
    typedef logic [$clog2(`RASTER_HEIGHT)-1:0] coord_y_t;

    typedef logic signed [SUB_W-1:0]                  sub_coord_t;
    typedef logic signed [2*SUB_W-1:0]                area_t;
    typedef logic signed [`RASTER_DENOM_INV_BITS-1:0] denom_inv_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } color12_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } color16_t;

    typedef logic signed [31:0] q16_16_t;

endpackage

// File: raster_defines.svh
`ifndef RASTER_DEFINES_SVH
`define RASTER_DEFINES_SVH

// Render target size in pixels
`define RASTER_WIDTH  16
`define RASTER_HEIGHT 16

// Fraction bits of vertex coordinates
`define RASTER_SUBPIXEL_BITS 4

// Signed reciprocal of the doubled area
`define RASTER_DENOM_INV_BITS  36
`define RASTER_DENOM_INV_FBITS 35

`endif
